// File: Makefile
# Verilator build, run, lint and clean for the memory front end

VERILATOR   ?= verilator
TOP         := elk_tb
FILELIST    := build.f
OBJ_DIR     := obj_dir
FLAGS       := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(shell sed -e '/^+/d' $(FILELIST)) source/elk_params.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+source
source/elk_pkg.sv
source/elk_bank_ram.sv
source/elk_page_decoder.sv
source/elk_tape_slicer.sv
source/elk_memory_front.sv
testbench/elk_clock_gen.sv
testbench/elk_properties.sv
testbench/elk_tb.sv

// File: source/elk_bank_ram.sv
// single-port synchronous store
// registered read, read-first on write
// word type is a parameter so bytes and adc samples share it
`timescale 1ns/1ps
`default_nettype none

module elk_bank_ram #(
	parameter type word_t = logic [7:0],
	parameter int ADDR_W = 17,
	parameter int DEPTH = 1 << ADDR_W
) (
	input  wire              clk_sys,
	input  wire [ADDR_W-1:0] addr,
	input  wire word_t       wdata,
	input  wire              we,
	output word_t            rdata
);

	// storage, no reset
	word_t mem [DEPTH];

	//////////////////////////////////////////////////
	// read then write on the same edge
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		// old contents come out even when writing
		// slicer fetches its oldest sample this way
		rdata <= mem[addr];
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// addresses past DEPTH read back unknown
	// rom store holds only 7 banks, its output
	// is selected for rom pages only

endmodule

`default_nettype wire

// File: source/elk_memory_front.sv
// electron external memory front end, top level
// page decoder with rom and sideways ram bank stores,
// plus the adc cassette slicer and its history ring
`timescale 1ns/1ps
`default_nettype none

`include "elk_params.svh"

module elk_memory_front (
	input  wire                    clk_sys,
	input  wire                    rst,
	input  wire elk_pkg::bus_req_t bus,
	input  wire                    loading,
	input  wire elk_pkg::load_wr_t load,
	input  wire elk_pkg::sample_t  adc_sample,
	input  wire                    adc_sync,
	output logic [7:0]             mem_rdata,
	output logic                   cassette_bit
);

	// rom and ram store ports
	logic [`ELK_BANK_ADDR_W-1:0] rom_addr;
	logic [7:0]                  rom_wdata;
	logic                        rom_we;
	logic [7:0]                  rom_rdata;
	logic [`ELK_BANK_ADDR_W-1:0] ram_addr;
	logic [7:0]                  ram_wdata;
	logic                        ram_we;
	logic [7:0]                  ram_rdata;
	// history ring port
	logic [$clog2(`ELK_HIST_DEPTH)-1:0] hist_addr;
	elk_pkg::sample_t                   hist_wdata;
	logic                               hist_we;
	elk_pkg::sample_t                   hist_rdata;

	//////////////////////////////////////////////////
	// memory
	//////////////////////////////////////////////////

	elk_page_decoder u_decoder (
		.clk_sys, .rst, .bus, .loading, .load,
		.rom_addr, .rom_wdata, .rom_we,
		.ram_addr, .ram_wdata, .ram_we,
		.rom_rdata, .ram_rdata, .mem_rdata
	);

	// seven 16 KB rom banks
	elk_bank_ram #(
		.word_t(logic [7:0]), .ADDR_W(`ELK_BANK_ADDR_W),
		.DEPTH(`ELK_ROM_BANKS << `ELK_PAGE_LSB)
	) rom_store (
		.clk_sys, .addr(rom_addr), .wdata(rom_wdata), .we(rom_we), .rdata(rom_rdata)
	);

	// eight 16 KB sideways ram banks
	elk_bank_ram #(
		.word_t(logic [7:0]), .ADDR_W(`ELK_BANK_ADDR_W),
		.DEPTH(`ELK_RAM_BANKS << `ELK_PAGE_LSB)
	) ram_store (
		.clk_sys, .addr(ram_addr), .wdata(ram_wdata), .we(ram_we), .rdata(ram_rdata)
	);

	//////////////////////////////////////////////////
	// tape
	//////////////////////////////////////////////////

	elk_bank_ram #(
		.word_t(elk_pkg::sample_t), .ADDR_W($clog2(`ELK_HIST_DEPTH)),
		.DEPTH(`ELK_HIST_DEPTH)
	) hist_store (
		.clk_sys, .addr(hist_addr), .wdata(hist_wdata), .we(hist_we), .rdata(hist_rdata)
	);

	elk_tape_slicer u_slicer (
		.clk_sys, .rst, .adc_sample, .adc_sync,
		.hist_addr, .hist_wdata, .hist_we, .hist_rdata,
		.cassette_bit
	);

endmodule

`default_nettype wire

// File: source/elk_page_decoder.sv
// electron external memory control
// decodes the page field to rom bank, ram bank or nothing,
// hands the rom port to the loader while loading,
// writes ram once per low phase of the write strobe
// and picks read data one cycle after the address
`timescale 1ns/1ps
`default_nettype none

`include "elk_params.svh"

module elk_page_decoder (
	input  wire                         clk_sys,
	input  wire                         rst,
	input  wire elk_pkg::bus_req_t      bus,
	input  wire                         loading,
	input  wire elk_pkg::load_wr_t      load,
	output logic [`ELK_BANK_ADDR_W-1:0] rom_addr,
	output logic [7:0]                  rom_wdata,
	output logic                        rom_we,
	output logic [`ELK_BANK_ADDR_W-1:0] ram_addr,
	output logic [7:0]                  ram_wdata,
	output logic                        ram_we,
	input  wire [7:0]                   rom_rdata,
	input  wire [7:0]                   ram_rdata,
	output logic [7:0]                  mem_rdata
);

	// page field and bank offset
	logic [`ELK_ADDR_W-`ELK_PAGE_LSB-1:0] page;
	logic [`ELK_PAGE_LSB-1:0]             offset;
	// decoded now, and one cycle back
	elk_pkg::page_sel_t sel;
	elk_pkg::page_sel_t sel_q;
	// strobe level last cycle
	logic we_n_q;

	assign page   = bus.addr[`ELK_ADDR_W-1:`ELK_PAGE_LSB];
	assign offset = bus.addr[`ELK_PAGE_LSB-1:0];

	//////////////////////////////////////////////////
	// page map
	//////////////////////////////////////////////////

	always_comb begin
		// unmapped unless listed
		sel.target = elk_pkg::TGT_NONE;
		sel.bank   = '0;
		casez (page)
			5'b0_01_00: begin
				sel.target = elk_pkg::TGT_ROM;
				sel.bank   = 3'd0;
			end
			// os, mirrored over two pages
			5'b0_10_0?: begin
				sel.target = elk_pkg::TGT_ROM;
				sel.bank   = 3'd1;
			end
			// basic, mirrored too
			5'b0_10_1?: begin
				sel.target = elk_pkg::TGT_ROM;
				sel.bank   = 3'd2;
			end
			// 0_11_xx gives banks 3 to 6
			5'b0_11_??: begin
				sel.target = elk_pkg::TGT_ROM;
				sel.bank   = 3'd3 + {1'b0, page[1:0]};
			end
			// sideways ram, bank is the low page bits
			5'b1_0?_??: begin
				sel.target = elk_pkg::TGT_RAM;
				sel.bank   = page[2:0];
			end
			default: begin
				sel.target = elk_pkg::TGT_NONE;
				sel.bank   = '0;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// store ports
	//////////////////////////////////////////////////

	// loader owns the rom while loading
	assign rom_addr  = loading ? load.addr : {sel.bank, offset};
	assign rom_wdata = load.data;
	assign rom_we    = loading & load.valid;

	assign ram_addr  = {sel.bank, offset};
	assign ram_wdata = bus.wdata;
	// first low cycle after a high one, ram pages only
	assign ram_we    = we_n_q & ~bus.we_n & (sel.target == elk_pkg::TGT_RAM);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			we_n_q <= 1'b1;
			sel_q  <= '{target: elk_pkg::TGT_NONE, bank: '0};
		end else begin
			we_n_q <= bus.we_n;
			// lines up with the registered store output
			sel_q  <= sel;
		end
	end

	// read data mux
	always_comb begin
		case (sel_q.target)
			elk_pkg::TGT_ROM: mem_rdata = rom_rdata;
			elk_pkg::TGT_RAM: mem_rdata = ram_rdata;
			default:          mem_rdata = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: source/elk_params.svh
// electron memory front end and tape slicer
// shared width, bank and threshold constants
// page field sits above a 14-bit bank offset
`ifndef ELK_PARAMS_SVH
`define ELK_PARAMS_SVH

// cpu side address bus
`define ELK_ADDR_W 19
// lowest bit of the 5-bit page field
`define ELK_PAGE_LSB 14
// one bank store, eight 16 KB slots
`define ELK_BANK_ADDR_W 17

// populated banks
`define ELK_ROM_BANKS 7
`define ELK_RAM_BANKS 8

// adc tape input
`define ELK_SAMPLE_W 12
// running average window, in samples
`define ELK_HIST_DEPTH 512
// total to average, log2 of the window
`define ELK_HIST_SHIFT 9
// enough for 512 full-scale samples
`define ELK_TOTAL_W 22
// hysteresis around the average, in counts
`define ELK_TAPE_HYST 100

`endif

// File: source/elk_pkg.sv
// electron memory front end types
// cpu request, rom loader word, decoded page target
// and the adc sample used by the tape slicer
`default_nettype none

`include "elk_params.svh"

package elk_pkg;

	// what a page maps to
	typedef enum logic [1:0] {
		TGT_NONE = 2'd0,
		TGT_ROM  = 2'd1,
		TGT_RAM  = 2'd2
	} target_e;

	// raw adc reading, unsigned
	typedef logic [`ELK_SAMPLE_W-1:0] sample_t;

	// cpu side strobe bus
	typedef struct packed {
		logic [`ELK_ADDR_W-1:0] addr;
		logic [7:0]             wdata;
		// low while writing
		logic                   we_n;
	} bus_req_t;

	// one byte from the rom loader
	typedef struct packed {
		logic [`ELK_BANK_ADDR_W-1:0] addr;
		logic [7:0]                  data;
		logic                        valid;
	} load_wr_t;

	// decoded page, bank number within rom or ram
	typedef struct packed {
		target_e                                   target;
		logic [`ELK_BANK_ADDR_W-`ELK_PAGE_LSB-1:0] bank;
	} page_sel_t;

endpackage

`default_nettype wire

// File: source/elk_tape_slicer.sv
// cassette slicer for the adc tape input
// keeps a running total of the last 512 samples in a ring
// held in an external store, and turns each new sample
// into a tape bit with hysteresis around the average
`timescale 1ns/1ps
`default_nettype none

`include "elk_params.svh"

module elk_tape_slicer (
	input  wire                                clk_sys,
	input  wire                                rst,
	input  wire elk_pkg::sample_t              adc_sample,
	input  wire                                adc_sync,
	output logic [$clog2(`ELK_HIST_DEPTH)-1:0] hist_addr,
	output elk_pkg::sample_t                   hist_wdata,
	output logic                               hist_we,
	input  wire elk_pkg::sample_t              hist_rdata,
	output logic                               cassette_bit
);

	localparam int PTR_W = $clog2(`ELK_HIST_DEPTH);
	localparam int CMP_W = `ELK_SAMPLE_W + 1;

	// step sequencer, one pass per sample
	typedef enum logic [1:0] {
		S_IDLE,
		S_CMP,
		S_SUM,
		S_AVG
	} step_e;

	step_e                   state;
	logic                    sync_q;
	logic                    event_hit;
	// latched sample, payload only
	elk_pkg::sample_t        sample_q;
	logic [PTR_W-1:0]        ptr_q;
	// slots written so far, saturates at depth
	logic [PTR_W:0]          hist_cnt;
	logic [`ELK_TOTAL_W-1:0] total_q;
	elk_pkg::sample_t        avg_q;
	elk_pkg::sample_t        old_sample;
	// widened for the hysteresis compare
	logic [CMP_W-1:0]        samp_w;
	logic [CMP_W-1:0]        avg_w;
	logic [CMP_W-1:0]        hyst_w;

	assign event_hit = adc_sync ^ sync_q;

	// unwritten slots count as zero
	// ring is full once the top count bit sets
	assign old_sample = hist_cnt[PTR_W] ? hist_rdata : '0;

	assign samp_w = {1'b0, sample_q};
	assign avg_w  = {1'b0, avg_q};
	assign hyst_w = CMP_W'(`ELK_TAPE_HYST);

	//////////////////////////////////////////////////
	// ring write, read-first returns the oldest
	//////////////////////////////////////////////////

	assign hist_addr  = ptr_q;
	assign hist_wdata = sample_q;
	assign hist_we    = (state == S_CMP);

	always_ff @(posedge clk_sys) begin
		// new sample on the toggle
		if (state == S_IDLE && event_hit) begin
			sample_q <= adc_sample;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state        <= S_IDLE;
			sync_q       <= 1'b0;
			ptr_q        <= '0;
			hist_cnt     <= '0;
			total_q      <= '0;
			avg_q        <= '0;
			cassette_bit <= 1'b0;
		end else begin
			sync_q <= adc_sync;
			case (state)
				S_IDLE: begin
					if (event_hit) begin
						state <= S_CMP;
					end
				end
				// compare against the average of the
				// previous 512, write the ring slot
				S_CMP: begin
					if (samp_w + hyst_w < avg_w) begin
						cassette_bit <= 1'b1;
					end else if (samp_w > avg_w + hyst_w) begin
						cassette_bit <= 1'b0;
					end
					state <= S_SUM;
				end
				// drop the oldest, add the newest
				S_SUM: begin
					total_q <= total_q - `ELK_TOTAL_W'(old_sample)
						+ `ELK_TOTAL_W'(sample_q);
					ptr_q   <= ptr_q + 1'b1;
					if (!hist_cnt[PTR_W]) begin
						hist_cnt <= hist_cnt + 1'b1;
					end
					state   <= S_AVG;
				end
				// average for the next sample
				S_AVG: begin
					avg_q <= total_q[`ELK_HIST_SHIFT +: `ELK_SAMPLE_W];
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: testbench/elk_clock_gen.sv
// testbench clock and reset source
// 4 ns clock, reset held high for five cycles
`timescale 1ns/1ps
`default_nettype none

module elk_clock_gen #(
	parameter realtime PERIOD = 4.0
) (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2.0) clk_sys = ~clk_sys;
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk_sys);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: testbench/elk_properties.sv
// bound checks on the memory front end top level
// tape bit held low in reset, unmapped pages read zero
`timescale 1ns/1ps
`default_nettype none

`include "elk_params.svh"

module elk_properties (
	input wire                    clk_sys,
	input wire                    rst,
	input wire elk_pkg::bus_req_t bus,
	input wire [7:0]              mem_rdata,
	input wire                    cassette_bit
);

	logic [`ELK_ADDR_W-`ELK_PAGE_LSB-1:0] page;
	logic                                 unmapped;

	assign page = bus.addr[`ELK_ADDR_W-1:`ELK_PAGE_LSB];
	// 0_00_xx, 0_01_01 to 0_01_11, 1_1x_xx
	assign unmapped = (page < 5'd4) || (page >= 5'd5 && page <= 5'd7) || (page >= 5'd24);

	cassette_low_in_reset: assert property (@(posedge clk_sys) rst |=> !cassette_bit)
		else $error("cassette_bit not low while reset is applied");

	// read data one cycle after the address
	unmapped_reads_zero: assert property (@(posedge clk_sys) disable iff (rst)
		unmapped |=> (mem_rdata == 8'h00))
		else $error("unmapped page returned nonzero read data");

endmodule

bind elk_memory_front elk_properties u_props (
	.clk_sys, .rst, .bus, .mem_rdata, .cassette_bit
);

`default_nettype wire

// File: testbench/elk_tb.sv
// testbench for the electron memory front end
// rom loading, sideways ram strobe writes, unmapped pages
// and the cassette slicer against reference models
`timescale 1ns/1ps
`default_nettype none

`include "elk_params.svh"

module elk_tb;

	localparam int N_OFFS    = 32;
	localparam int N_SAMPLES = 600;
	// rough cycle budget of every phase
	localparam int RUN_CYCLES = 20 + 7 * N_OFFS + 7 * 8 + 9 * N_OFFS * 3
		+ 8 * 4 * 4 + 8 * 4 * 2 + 16 * 4 * 2 + 25 * 4 + N_SAMPLES * 8;
	localparam realtime LIMIT_NS = 2.0 * RUN_CYCLES * 4.0;

	logic              clk_sys;
	logic              rst;
	elk_pkg::bus_req_t bus;
	logic              loading;
	elk_pkg::load_wr_t load;
	elk_pkg::sample_t  adc_sample;
	logic              adc_sync;
	logic [7:0]        mem_rdata;
	logic              cassette_bit;

	logic [15:0] lfsr_q;
	// byte models keyed by bank store address
	logic [7:0]  rom_model [int];
	logic [7:0]  ram_model [int];
	// slicer model, last 512 samples
	int          tape_q [$];
	int          tape_total;
	logic        tape_bit;
	logic        rd_check;
	logic        rd_check_q;
	logic [7:0]  rd_expect;
	logic [7:0]  rd_expect_q;

	elk_clock_gen u_clk (.clk_sys, .rst);

	elk_memory_front dut0 (
		.clk_sys, .rst, .bus, .loading, .load,
		.adc_sample, .adc_sync, .mem_rdata, .cassette_bit
	);

	//////////////////////////////////////////////////
	// reference models
	//////////////////////////////////////////////////

	// galois lfsr, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
		end
		return r;
	endfunction

	// 0 none, 1 rom, 2 ram
	function automatic int decode_page(input int page, output int bank);
		bank = 0;
		if (page == 4) return 1;
		if (page == 8 || page == 9) begin
			bank = 1;
			return 1;
		end
		if (page == 10 || page == 11) begin
			bank = 2;
			return 1;
		end
		if (page >= 12 && page <= 15) begin
			bank = page - 9;
			return 1;
		end
		if (page >= 16 && page <= 23) begin
			bank = page - 16;
			return 2;
		end
		return 0;
	endfunction

	function automatic logic [7:0] expected_read(input int addr);
		int bank;
		int tgt;
		int key;
		tgt = decode_page(addr >> 14, bank);
		key = bank * 16384 + (addr % 16384);
		if (tgt == 1) return rom_model[key];
		if (tgt == 2) return ram_model[key];
		return 8'h00;
	endfunction

	// hysteresis around the average of the previous 512
	function automatic logic slicer_next(input int s);
		int avg;
		avg = tape_total / 512;
		if (avg >= 100 && s < avg - 100) tape_bit = 1'b1;
		else if (s > avg + 100) tape_bit = 1'b0;
		tape_q.push_back(s);
		tape_total += s;
		if (tape_q.size() > 512) tape_total -= tape_q.pop_front();
		return tape_bit;
	endfunction

	function automatic int offset_of(input int i);
		return (i * 509 + 7) % 16384;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("** FAIL **");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	//////////////////////////////////////////////////
	// drivers
	//////////////////////////////////////////////////

	task automatic read_addr(input int addr);
		@(posedge clk_sys);
		bus       <= '{addr: `ELK_ADDR_W'(addr), wdata: 8'h00, we_n: 1'b1};
		rd_check  <= 1'b1;
		rd_expect <= expected_read(addr);
	endtask

	// strobe low for n cycles, data changes each cycle
	task automatic write_strobe(input int addr, input int n);
		int bank;
		logic [7:0] d;
		for (int i = 0; i < n; i++) begin
			d = 8'(take_bits(8));
			@(posedge clk_sys);
			bus      <= '{addr: `ELK_ADDR_W'(addr), wdata: d, we_n: 1'b0};
			rd_check <= 1'b0;
			if (i == 0 && decode_page(addr >> 14, bank) == 2)
				ram_model[bank * 16384 + (addr % 16384)] = d;
		end
		@(posedge clk_sys);
		bus <= '{addr: `ELK_ADDR_W'(addr), wdata: 8'h00, we_n: 1'b1};
	endtask

	task automatic load_word(input int addr, input logic [7:0] d, input logic ld);
		@(posedge clk_sys);
		loading  <= ld;
		load     <= '{addr: `ELK_BANK_ADDR_W'(addr), data: d, valid: 1'b1};
		rd_check <= 1'b0;
		if (ld) rom_model[addr] = d;
	endtask

	task automatic load_end();
		@(posedge clk_sys);
		loading <= 1'b0;
		load    <= '0;
	endtask

	task automatic read_rom_pages();
		int pages[9] = '{4, 8, 9, 10, 11, 12, 13, 14, 15};
		foreach (pages[p])
			for (int i = 0; i < N_OFFS; i++) read_addr(pages[p] * 16384 + offset_of(i));
	endtask

	task automatic send_sample(input int s);
		logic exp;
		exp = slicer_next(s);
		@(posedge clk_sys);
		adc_sample <= `ELK_SAMPLE_W'(s);
		adc_sync   <= ~adc_sync;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		compare_value("cassette_bit", 32'(cassette_bit), 32'(exp));
		repeat (3) @(posedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// read compare, one cycle after the address
	//////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		rd_check_q  <= rd_check;
		rd_expect_q <= rd_expect;
	end

	always @(negedge clk_sys) begin
		if (rd_check_q) compare_value("mem_rdata", 32'(mem_rdata), 32'(rd_expect_q));
	end

	initial begin
		#(LIMIT_NS);
		$display("** FAIL **");
		$fatal(1, "watchdog expired before the tests finished");
	end

	initial begin
		int unm[15] = '{0, 1, 2, 3, 5, 6, 7, 24, 25, 26, 27, 28, 29, 30, 31};
		int wpages[6] = '{4, 9, 14, 2, 6, 27};
		bus         = '{addr: '0, wdata: 8'h00, we_n: 1'b1};
		loading     = 1'b0;
		load        = '0;
		adc_sample  = '0;
		adc_sync    = 1'b0;
		rd_check    = 1'b0;
		rd_check_q  = 1'b0;
		rd_expect   = 8'h00;
		rd_expect_q = 8'h00;
		lfsr_q      = 16'd36;
		tape_total  = 0;
		tape_bit    = 1'b0;
		do @(posedge clk_sys); while (rst);

		// rom load, then every rom page incl. mirrors
		for (int b = 0; b < 7; b++)
			for (int i = 0; i < N_OFFS; i++)
				load_word(b * 16384 + offset_of(i), 8'(take_bits(8)), 1'b1);
		load_end();
		read_rom_pages();

		// loader words ignored while loading is low
		for (int b = 0; b < 7; b++)
			for (int i = 0; i < 8; i++)
				load_word(b * 16384 + offset_of(i), 8'(take_bits(8)), 1'b0);
		load_end();
		read_rom_pages();

		// first strobe cycle only, per ram page
		for (int r = 0; r < 8; r++)
			for (int i = 0; i < 4; i++) write_strobe((16 + r) * 16384 + offset_of(i), 3);
		for (int r = 0; r < 8; r++)
			for (int i = 0; i < 4; i++) read_addr((16 + r) * 16384 + offset_of(i));

		// unmapped reads and ignored writes
		for (int p = 0; p < 15; p++)
			for (int i = 0; i < 4; i++) read_addr(unm[p] * 16384 + offset_of(i));
		foreach (wpages[p])
			for (int i = 0; i < 4; i++) write_strobe(wpages[p] * 16384 + offset_of(i), 2);
		read_rom_pages();
		for (int r = 0; r < 8; r++)
			for (int i = 0; i < 4; i++) read_addr((16 + r) * 16384 + offset_of(i));
		for (int p = 0; p < 15; p++) read_addr(unm[p] * 16384 + offset_of(1));
		@(posedge clk_sys);
		rd_check <= 1'b0;
		repeat (2) @(posedge clk_sys);

		// tape stream, high and low bursts of 40
		for (int n = 0; n < N_SAMPLES; n++) begin
			if ((n / 40) % 2 == 1) send_sample(2800 + take_bits(10));
			else send_sample(take_bits(10));
		end

		repeat (4) @(posedge clk_sys);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
